/* src.f */
camPkg.sv
streamIfs.sv
sensorCapture.sv
lineBuffer.sv
bayerDemosaic.sv
viewProcessor.sv
segDisplay.sv
cameraTop.sv
cameraTop_props.sv
tbCameraTop.sv

/* tbCameraTop.sv */
// ============================
// Testbench for cameraTop with 16-pixel lines and 8-line frames
// Immediate assertions check outputs against a queue model
// View mode only changes between frames
// ============================

`timescale 1ns/1ps

module tbCameraTop
  import camPkg::*;
();

  localparam int lineWidth     = 16;
  localparam int frameLines    = 8;
  localparam int grayThreshold = 2048;
  localparam int clkPeriod     = 200;
  localparam int leadCycles    = 2;
  localparam int lineGap       = 4;
  localparam int frameGap      = 6;
  localparam int numFrames     = 8;
  localparam int frameCycles   = 1 + leadCycles + frameLines * (lineWidth + lineGap) + frameGap;
  localparam int watchdogTime  = 2 * numFrames * frameCycles * clkPeriod;

  // Active-low hex font, bit 0 is segment a
  localparam logic [6:0] segFont [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic        D5M_PIXLCLK;
  logic        arstN;
  logic [11:0] pixelIn;
  logic        fval;
  logic        lval;
  logic        startReq;
  logic        endReq;
  logic [1:0]  viewSelect;
  logic [11:0] red;
  logic [11:0] green;
  logic [11:0] blue;
  logic        outValid;
  logic [31:0] frameCount;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;
  logic [41:0] hexBus;

  int unsigned cycleNum = 0;
  int unsigned expFrames = 0;
  int          mismatchErrors = 0;
  int          otherErrors = 0;
  int unsigned expCycleQ [$];
  logic [35:0] expRgbQ [$];
  string       nameQ [$];

  assign hexBus = {hex5, hex4, hex3, hex2, hex1, hex0};

  cameraTop #(
    .lineWidth     (lineWidth),
    .grayThreshold (grayThreshold)
  ) UUT (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .arstN       (arstN),
    .pixelIn     (pixelIn),
    .fval        (fval),
    .lval        (lval),
    .startReq    (startReq),
    .endReq      (endReq),
    .viewSelect  (viewSelect),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .outValid    (outValid),
    .frameCount  (frameCount),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5)
  );

  bind cameraTop cameraTopProps props (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .arstN       (arstN),
    .outValid    (outValid),
    .frameCount  (frameCount),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5)
  );

  initial
  begin
    D5M_PIXLCLK = 1'b0;
    forever #(clkPeriod / 2) D5M_PIXLCLK = ~D5M_PIXLCLK;
  end

  always @(posedge D5M_PIXLCLK)
  begin
    cycleNum <= cycleNum + 1;
  end

  // ============================
  // Checking helpers
  // ============================

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      mismatchErrors++;
      $display("MISMATCH %s expected %0h actual %0h", testName, expected, actual);
    end
  endtask

  // View rule applied to one demosaiced block
  function automatic logic [35:0] applyView(input logic [1:0] mode, input int r,
                                            input int g, input int b);
    int gray;
    int level;
    gray  = (r + 2 * g + b) / 4;
    level = (gray >= grayThreshold) ? 4095 : 0;
    case (mode)
      2'd1:    applyView = {12'(gray), 12'(gray), 12'(gray)};
      2'd2:    applyView = {12'(level), 12'(level), 12'(level)};
      default: applyView = {12'(r), 12'(g), 12'(b)};
    endcase
  endfunction

  task automatic checkDisplay(input string testName);
    logic [23:0] low;
    low = 24'(expFrames);
    checkValue({testName, " frameCount"}, expFrames, frameCount);
    for (int i = 0; i < 6; i++)
      checkValue($sformatf("%s hex%0d", testName, i), segFont[low[i*4 +: 4]], hexBus[i*7 +: 7]);
  endtask

  task automatic reportAndFinish();
    $display("Errors: %0d mismatch, %0d other, %0d assertion",
             mismatchErrors, otherErrors, UUT.props.assertFails);
    if (mismatchErrors == 0 && otherErrors == 0 && UUT.props.assertFails == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  // ============================
  // Output monitor
  // ============================

  always @(negedge D5M_PIXLCLK)
  begin : outputMonitor
    logic [35:0] expRgb;
    string       testName;
    if (arstN && outValid)
    begin
      if (expCycleQ.size() == 0)
      begin
        otherErrors++;
        $display("outValid went high at cycle %0d with no block pending", cycleNum);
      end
      else
      begin
        testName = nameQ.pop_front();
        expRgb   = expRgbQ.pop_front();
        checkValue({testName, " latency"}, expCycleQ.pop_front(), cycleNum);
        checkValue({testName, " red"}, expRgb[35:24], red);
        checkValue({testName, " green"}, expRgb[23:12], green);
        checkValue({testName, " blue"}, expRgb[11:0], blue);
      end
    end
    else if (expCycleQ.size() != 0 && expCycleQ[0] < cycleNum)
    begin
      otherErrors++;
      $display("%s block expected at cycle %0d never appeared", nameQ[0], expCycleQ[0]);
      void'(expCycleQ.pop_front());
      void'(expRgbQ.pop_front());
      void'(nameQ.pop_front());
    end
  end

  // ============================
  // Stimulus
  // ============================

  task automatic driveCycle(input logic fv, input logic lv, input logic [11:0] data,
                            input logic stop);
    @(posedge D5M_PIXLCLK);
    fval    <= fv;
    lval    <= lv;
    pixelIn <= data;
    endReq  <= stop;
  endtask

  task automatic pulseStart();
    @(posedge D5M_PIXLCLK);
    startReq <= 1'b1;
    @(posedge D5M_PIXLCLK);
    startReq <= 1'b0;
  endtask

  // One sensor frame, expected blocks queued when captured
  task automatic sendFrame(input string name, input logic [1:0] mode, input bit captured,
                           input bit stopMid);
    pixelT frame [frameLines][lineWidth];
    int    r;
    int    g;
    int    b;
    @(posedge D5M_PIXLCLK);
    viewSelect <= mode;
    for (int y = 0; y < frameLines; y++)
    begin
      for (int x = 0; x < lineWidth; x++)
      begin
        frame[y][x] = pixelT'($urandom);
        // Uniform blocks right at and just under the threshold
        if (mode != 2'd0 && (x / 2) % 4 == 0)
          frame[y][x] = pixelT'(grayThreshold);
        else if (mode != 2'd0 && (x / 2) % 4 == 1)
          frame[y][x] = pixelT'(grayThreshold - 1);
      end
    end
    repeat (leadCycles) driveCycle(1'b1, 1'b0, '0, 1'b0);
    for (int y = 0; y < frameLines; y++)
    begin
      for (int x = 0; x < lineWidth; x++)
      begin
        driveCycle(1'b1, 1'b1, frame[y][x], stopMid && y == 4 && x == 0);
        if (captured && y % 2 == 1 && x % 2 == 1)
        begin
          r = frame[y-1][x];
          b = frame[y][x-1];
          g = (frame[y-1][x-1] + frame[y][x]) / 2;
          expRgbQ.push_back(applyView(mode, r, g, b));
          // Drive edge plus four register stages
          expCycleQ.push_back(cycleNum + 5);
          nameQ.push_back(name);
        end
      end
      repeat (lineGap) driveCycle(1'b1, 1'b0, '0, 1'b0);
    end
    repeat (frameGap) driveCycle(1'b0, 1'b0, '0, 1'b0);
    if (captured)
      expFrames++;
    @(negedge D5M_PIXLCLK);
    checkDisplay(name);
  endtask

  initial
  begin
    #(watchdogTime);
    otherErrors++;
    $display("Watchdog expired before all frames were sent");
    reportAndFinish();
  end

  initial
  begin
    void'($urandom(32'h7bdb8e25));
    arstN      = 1'b0;
    pixelIn    = '0;
    fval       = 1'b0;
    lval       = 1'b0;
    startReq   = 1'b0;
    endReq     = 1'b0;
    viewSelect = 2'd0;
    repeat (8) @(posedge D5M_PIXLCLK);
    arstN <= 1'b1;
    @(negedge D5M_PIXLCLK);
    checkValue("reset outValid", 32'd0, outValid);
    checkDisplay("reset");

    sendFrame("idle", 2'd0, 1'b0, 1'b0);
    pulseStart();
    sendFrame("colour1", 2'd0, 1'b1, 1'b0);
    sendFrame("colour2", 2'd0, 1'b1, 1'b0);
    sendFrame("gray", 2'd1, 1'b1, 1'b0);
    sendFrame("threshold", 2'd2, 1'b1, 1'b0);
    sendFrame("stop", 2'd0, 1'b1, 1'b1);
    sendFrame("stopped", 2'd0, 1'b0, 1'b0);
    pulseStart();
    sendFrame("resume", 2'd3, 1'b1, 1'b0);

    repeat (8) @(posedge D5M_PIXLCLK);
    if (expCycleQ.size() != 0)
    begin
      otherErrors++;
      $display("%0d expected blocks still pending at the end", expCycleQ.size());
    end
    reportAndFinish();
  end

endmodule

/* cameraTop_props.sv */
// ============================
// Bound into cameraTop
// Reset, frame counter and display properties
// ============================

`timescale 1ns/1ps

module cameraTopProps
(
  input logic        D5M_PIXLCLK,
  input logic        arstN,
  input logic        outValid,
  input logic [31:0] frameCount,
  input logic [6:0]  hex0,
  input logic [6:0]  hex1,
  input logic [6:0]  hex2,
  input logic [6:0]  hex3,
  input logic [6:0]  hex4,
  input logic [6:0]  hex5
);

  int assertFails = 0;

  // Reset held over a full cycle keeps the output strobe low
  resetQuiet: assert property (@(posedge D5M_PIXLCLK)
    (!arstN && $past(!arstN)) |-> !outValid)
  else
  begin
    assertFails++;
    $error("outValid high while arstN is low");
  end

  // Unsigned difference catches both jumps and decrements
  frameStep: assert property (@(posedge D5M_PIXLCLK) disable iff (!arstN)
    (frameCount - $past(frameCount)) <= 32'd1)
  else
  begin
    assertFails++;
    $error("frameCount stepped by more than one");
  end

  hexKnown: assert property (@(posedge D5M_PIXLCLK) disable iff (!arstN)
    !$isunknown({hex5, hex4, hex3, hex2, hex1, hex0}))
  else
  begin
    assertFails++;
    $error("hex outputs hold an unknown value");
  end

endmodule

/* cameraTop.sv */
// ============================
// Camera pixel path, all on the D5M pixel clock
// Sample to outValid is exactly 4 cycles
// Lines must be lineWidth samples long
// ============================

`timescale 1ns/1ps

module cameraTop
  import camPkg::*;
#(
  parameter int lineWidth     = 1280,
  parameter int grayThreshold = 2048
)
(
  input  logic        D5M_PIXLCLK,
  input  logic        arstN,
  input  logic [11:0] pixelIn,
  input  logic        fval,
  input  logic        lval,
  input  logic        startReq,
  input  logic        endReq,
  input  logic [1:0]  viewSelect,
  output logic [11:0] red,
  output logic [11:0] green,
  output logic [11:0] blue,
  output logic        outValid,
  output logic [31:0] frameCount,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  pixelStreamIf pixStream ();
  rgbStreamIf   rgbStream ();

  // ============================
  // Capture, demosaic, view
  // ============================

  sensorCapture capture (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .arstN       (arstN),
    .pixelIn     (pixelIn),
    .fval        (fval),
    .lval        (lval),
    .startReq    (startReq),
    .endReq      (endReq),
    .frameCount  (frameCount),
    .pix         (pixStream.source)
  );

  bayerDemosaic #(
    .lineWidth (lineWidth)
  ) demosaic (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .arstN       (arstN),
    .pix         (pixStream.sink),
    .rgb         (rgbStream.source)
  );

  viewProcessor #(
    .grayThreshold (grayThreshold)
  ) view (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .arstN       (arstN),
    .rgb         (rgbStream.sink),
    .viewSelect  (viewModeT'(viewSelect)),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .outValid    (outValid)
  );

  // Low 24 bits of the frame count
  segDisplay display (
    .digits (frameCount[23:0]),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

endmodule

/* segDisplay.sv */
// ============================
// Six hex digits, active low segments
// Purely combinational, hex0 is the lowest nibble
// ============================

`timescale 1ns/1ps

module segDisplay
  import camPkg::*;
(
  input  digitsT digits,
  output segT    hex0,
  output segT    hex1,
  output segT    hex2,
  output segT    hex3,
  output segT    hex4,
  output segT    hex5
);

  // Font in g..a order, 0 lights a segment
  function automatic segT segDecode(input logic [3:0] nibble);
    case (nibble)
      4'h0:    segDecode = 7'b1000000;
      4'h1:    segDecode = 7'b1111001;
      4'h2:    segDecode = 7'b0100100;
      4'h3:    segDecode = 7'b0110000;
      4'h4:    segDecode = 7'b0011001;
      4'h5:    segDecode = 7'b0010010;
      4'h6:    segDecode = 7'b0000010;
      4'h7:    segDecode = 7'b1111000;
      4'h8:    segDecode = 7'b0000000;
      4'h9:    segDecode = 7'b0010000;
      4'hA:    segDecode = 7'b0001000;
      4'hB:    segDecode = 7'b0000011;
      4'hC:    segDecode = 7'b1000110;
      4'hD:    segDecode = 7'b0100001;
      4'hE:    segDecode = 7'b0000110;
      default: segDecode = 7'b0001110;
    endcase
  endfunction

  assign hex0 = segDecode(digits[3:0]);
  assign hex1 = segDecode(digits[7:4]);
  assign hex2 = segDecode(digits[11:8]);
  assign hex3 = segDecode(digits[15:12]);
  assign hex4 = segDecode(digits[19:16]);
  assign hex5 = segDecode(digits[23:20]);

endmodule

/* viewProcessor.sv */
// ============================
// Colour, gray or binary view, one cycle latency
// viewSelect is taken in the RGB strobe cycle
// ============================

`timescale 1ns/1ps

module viewProcessor
  import camPkg::*;
#(
  parameter int grayThreshold = 2048
)
(
  input  logic     D5M_PIXLCLK,
  input  logic     arstN,
  rgbStreamIf.sink rgb,
  input  viewModeT viewSelect,
  output pixelT    red,
  output pixelT    green,
  output pixelT    blue,
  output logic     outValid
);

  localparam pixelT thresholdLevel = pixelT'(grayThreshold);

  logic [13:0] lumaSum;
  pixelT       gray;
  pixelT       binary;

  // Weights 1:2:1, sum fits in 14 bits
  assign lumaSum = {2'b00, rgb.red} + {1'b0, rgb.green, 1'b0} + {2'b00, rgb.blue};
  assign gray    = lumaSum[13:2];
  assign binary  = {12{gray >= thresholdLevel}};

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (rgb.valid)
    begin
      case (viewSelect)
        viewGray:
        begin
          red   <= gray;
          green <= gray;
          blue  <= gray;
        end
        viewThreshold:
        begin
          red   <= binary;
          green <= binary;
          blue  <= binary;
        end
        default:
        begin
          red   <= rgb.red;
          green <= rgb.green;
          blue  <= rgb.blue;
        end
      endcase
    end
  end

  always_ff @(posedge D5M_PIXLCLK or negedge arstN)
  begin
    if (!arstN)
      outValid <= 1'b0;
    else
      outValid <= rgb.valid;
  end

endmodule

/* bayerDemosaic.sv */
// ============================
// 2x2 Bayer block to one RGB pixel, one cycle latency
// Layout: even line G R, odd line B G
// Output rate is a quarter of the sample rate
// ============================

`timescale 1ns/1ps

module bayerDemosaic
  import camPkg::*;
#(
  parameter int lineWidth = 1280
)
(
  input  logic       D5M_PIXLCLK,
  input  logic       arstN,
  pixelStreamIf.sink pix,
  rgbStreamIf.source rgb
);

  pixelT       upper;
  pixelT       prevCur;
  pixelT       prevUpper;
  logic [12:0] greenSum;
  logic        blockDone;

  // Previous line, same column
  lineBuffer #(
    .lineWidth (lineWidth)
  ) rowDelay (
    .D5M_PIXLCLK (D5M_PIXLCLK),
    .arstN       (arstN),
    .shiftEn     (pix.valid),
    .dataIn      (pix.data),
    .dataOut     (upper)
  );

  // ============================
  // 2x2 window
  // ============================

  // Left column of the window, one sample back
  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (pix.valid)
    begin
      prevCur   <= pix.data;
      prevUpper <= upper;
    end
  end

  // Lower-right sample closes the block
  assign blockDone = pix.valid & pix.y[0] & pix.x[0];

  // Mean of the two greens on the diagonal
  assign greenSum = {1'b0, prevUpper} + {1'b0, pix.data};

  // ============================
  // RGB output register
  // ============================

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (blockDone)
    begin
      rgb.red   <= upper;
      rgb.green <= greenSum[12:1];
      rgb.blue  <= prevCur;
    end
  end

  always_ff @(posedge D5M_PIXLCLK or negedge arstN)
  begin
    if (!arstN)
      rgb.valid <= 1'b0;
    else
      rgb.valid <= blockDone;
  end

endmodule

/* lineBuffer.sv */
// ============================
// One-line sample delay, advances only on shiftEn
// Read is asynchronous, so dataOut is valid in the shift cycle
// ============================

`timescale 1ns/1ps

module lineBuffer
  import camPkg::*;
#(
  parameter int lineWidth = 1280
)
(
  input  logic  D5M_PIXLCLK,
  input  logic  arstN,
  input  logic  shiftEn,
  input  pixelT dataIn,
  output pixelT dataOut
);

  localparam int ptrWidth = (lineWidth > 1) ? $clog2(lineWidth) : 1;

  pixelT               mem [lineWidth];
  logic [ptrWidth-1:0] wrPtr;

  // Oldest entry sits at the write slot
  assign dataOut = mem[wrPtr];

  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (shiftEn)
      mem[wrPtr] <= dataIn;
  end

  always_ff @(posedge D5M_PIXLCLK or negedge arstN)
  begin
    if (!arstN)
      wrPtr <= '0;
    else if (shiftEn)
      wrPtr <= (wrPtr == ptrWidth'(lineWidth - 1)) ? '0 : wrPtr + 1'b1;
  end

endmodule

/* sensorCapture.sv */
// ============================
// D5M capture, two cycles from pins to stream valid
// Capture starts only on startReq, never on its own
// Every line must carry the same number of samples
// ============================

`timescale 1ns/1ps

module sensorCapture
  import camPkg::*;
(
  input  logic         D5M_PIXLCLK,
  input  logic         arstN,
  input  pixelT        pixelIn,
  input  logic         fval,
  input  logic         lval,
  input  logic         startReq,
  input  logic         endReq,
  output frameCountT   frameCount,
  pixelStreamIf.source pix
);

  pixelT        dataReg;
  logic         fvalReg;
  logic         lvalReg;
  logic         fvalPrev;
  logic         lvalPrev;
  captureStateT state;
  logic         stopFlag;
  coordT        xCnt;
  coordT        yCnt;

  logic fvalRise;
  logic fvalFall;
  logic lvalFall;
  logic frameStart;
  logic sampleValid;

  // ============================
  // Sensor bus input register
  // ============================

  always_ff @(posedge D5M_PIXLCLK)
  begin
    dataReg <= pixelIn;
  end

  always_ff @(posedge D5M_PIXLCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      fvalReg  <= 1'b0;
      lvalReg  <= 1'b0;
      fvalPrev <= 1'b0;
      lvalPrev <= 1'b0;
    end
    else
    begin
      fvalReg  <= fval;
      lvalReg  <= lval;
      fvalPrev <= fvalReg;
      lvalPrev <= lvalReg;
    end
  end

  assign fvalRise = fvalReg & ~fvalPrev;
  assign fvalFall = ~fvalReg & fvalPrev;
  assign lvalFall = ~lvalReg & lvalPrev;

  // A sample on the very first frame cycle is kept too
  assign frameStart  = (state == captArmed) && fvalRise;
  assign sampleValid = ((state == captInFrame) || frameStart) && fvalReg && lvalReg;

  // ============================
  // Start and stop control
  // ============================

  always_ff @(posedge D5M_PIXLCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      state    <= captIdle;
      stopFlag <= 1'b0;
    end
    else
    begin
      case (state)
        captIdle:    if (startReq) state <= captArmed;
        captArmed:   if (fvalRise) state <= captInFrame;
        captInFrame: if (fvalFall) state <= stopFlag ? captIdle : captArmed;
        default:     state <= captIdle;
      endcase
      // Stop request waits for the end of the running frame
      if (endReq)
        stopFlag <= 1'b1;
      else if ((state == captInFrame && fvalFall) || (state == captIdle && startReq))
        stopFlag <= 1'b0;
    end
  end

  // ============================
  // Position and frame counters
  // ============================

  always_ff @(posedge D5M_PIXLCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      frameCount <= '0;
      xCnt       <= '0;
      yCnt       <= '0;
    end
    else if (frameStart)
    begin
      frameCount <= frameCount + 1'b1;
      xCnt       <= coordT'(sampleValid);
      yCnt       <= '0;
    end
    else if (state == captInFrame)
    begin
      if (lvalFall)
      begin
        xCnt <= '0;
        yCnt <= yCnt + 1'b1;
      end
      else if (sampleValid)
        xCnt <= xCnt + 1'b1;
    end
  end

  // Stream output register
  always_ff @(posedge D5M_PIXLCLK)
  begin
    if (sampleValid)
      pix.data <= dataReg;
  end

  always_ff @(posedge D5M_PIXLCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      pix.valid <= 1'b0;
      pix.x     <= '0;
      pix.y     <= '0;
    end
    else
    begin
      pix.valid <= sampleValid;
      if (sampleValid)
      begin
        pix.x <= frameStart ? '0 : xCnt;
        pix.y <= frameStart ? '0 : yCnt;
      end
    end
  end

endmodule

/* streamIfs.sv */
// ============================
// Stream interfaces between capture, demosaic and view stages
// valid is a single-cycle strobe, no back-pressure exists
// ============================

`timescale 1ns/1ps

// Raw Bayer samples with their position in the frame
interface pixelStreamIf
  import camPkg::*;
();

  pixelT data;
  logic  valid;
  coordT x;
  coordT y;

  modport source (
    output data,
    output valid,
    output x,
    output y
  );

  modport sink (
    input data,
    input valid,
    input x,
    input y
  );

endinterface

// One demosaiced RGB pixel per strobe
interface rgbStreamIf
  import camPkg::*;
();

  pixelT red;
  pixelT green;
  pixelT blue;
  logic  valid;

  modport source (
    output red,
    output green,
    output blue,
    output valid
  );

  modport sink (
    input red,
    input green,
    input blue,
    input valid
  );

endinterface

/* camPkg.sv */
// ============================
// Shared widths and enums for the pixel-clock path
// Sample width fixed at the 12-bit D5M sensor depth
// ============================

package camPkg;

  // ============================
  // Data widths
  // ============================

  // Raw sensor sample or one colour channel
  typedef logic [11:0] pixelT;

  // Column or line index
  typedef logic [15:0] coordT;

  // Frames started since reset
  typedef logic [31:0] frameCountT;

  // Part of the frame count shown on the display
  typedef logic [23:0] digitsT;

  // Active low, bit 0 is segment a, bit 6 is segment g
  typedef logic [6:0] segT;

  // ============================
  // Control encodings
  // ============================

  typedef enum logic [1:0] {
    captIdle,
    captArmed,
    captInFrame
  } captureStateT;

  // Code 3 is treated as colour
  typedef enum logic [1:0] {
    viewColor     = 2'd0,
    viewGray      = 2'd1,
    viewThreshold = 2'd2
  } viewModeT;

endpackage
